//--- include/ps2_consts.svh
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// --------------------------------------------------
// frame geometry
// --------------------------------------------------

// start, 8 data bits, parity, stop
`define PS2_FRAME_BITS 11

// parity sits just above the data byte
`define PS2_PARITY_POS 9

// --------------------------------------------------
// timing in cycles of a 50 MHz clk
// --------------------------------------------------

// cycles a raw line must hold still before it counts as clean
`define PS2_DEBOUNCE_LIMIT 15

// request-to-send clock hold of 100 us
`define PS2_DELAY_RTS 5000

// 20 us of data low before the clock is let go
`define PS2_DELAY_DATA_SETUP 1000

// guard after release that covers filter latency on our own clock pull
`define PS2_DELAY_RELEASE 63

`endif

//--- source/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

`include "ps2_consts.svh"

    // one data byte as seen by the client
    typedef logic [7:0] ps2_byte_t;

    // full frame as it sits in the shift register, start bit at index 0
    typedef logic [`PS2_FRAME_BITS-1:0] ps2_frame_t;

    // frame bits shifted in or out so far
    typedef logic [$clog2(`PS2_FRAME_BITS + 1)-1:0] ps2_bit_count_t;

    // rx_* states receive from the device, tx_* states send to it
    typedef enum logic [4:0] {
        idle,
        rx_clk_high,
        rx_fall,
        rx_clk_low,
        rx_check,
        rx_parity_error,
        rx_ready,
        tx_hold_clk,
        tx_data_low,
        tx_release_clk,
        tx_first_fall,
        tx_drive_bit,
        tx_wait_rise,
        tx_clk_high,
        tx_wait_ack_rise,
        tx_wait_ack,
        tx_acked,
        tx_no_ack
    } ps2_state_t;

endpackage

`default_nettype wire

//--- source/ps2_line_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_line_filter (
    input  logic clk,
    input  logic rst,
    input  logic raw,
    output logic level
);

    localparam int unsigned CNT_W = $clog2(`PS2_DEBOUNCE_LIMIT + 1);

    // last raw sample and how long it has held
    logic             last;
    logic [CNT_W-1:0] stable_count;
    // debounced value before the extra sync stage
    logic             clean;

    // --------------------------------------------------
    // debounce
    // --------------------------------------------------
    // idle bus is pulled up, so everything starts high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last         <= 1'b1;
            stable_count <= '0;
            clean        <= 1'b1;
            level        <= 1'b1;
        end else begin
            // any change restarts the stability count
            if (raw != last) begin
                last         <= raw;
                stable_count <= '0;
            end else if (stable_count == CNT_W'(`PS2_DEBOUNCE_LIMIT)) begin
                clean <= last;
            end else begin
                stable_count <= stable_count + 1'b1;
            end
            // one more stage toward the clk domain
            level <= clean;
        end
    end

endmodule

`default_nettype wire

//--- source/ps2_delay_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_delay_timer #(
    parameter int unsigned LIMIT = 63
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic done
);

    // at least one bit even for tiny limits
    localparam int unsigned WIDTH = (LIMIT > 1) ? $clog2(LIMIT + 1) : 1;

    logic [WIDTH-1:0] count;

    // count up while enabled, park at LIMIT with done held
    // dropping enable restarts from zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            done  <= 1'b0;
        end else if (!enable) begin
            count <= '0;
            done  <= 1'b0;
        end else if (count == WIDTH'(LIMIT)) begin
            done <= 1'b1;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/ps2_frame_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_frame_shifter
    import ps2_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           load_tx,
    input  logic           shift,
    input  logic           clear_count,
    input  logic           load_rx,
    input  logic           data_level,
    input  ps2_byte_t      tx_data,
    output ps2_bit_count_t bit_count,
    output logic           tx_bit,
    output logic           parity_ok,
    output ps2_byte_t      rx_data
);

    // bit 0 is the oldest bit on the wire
    ps2_frame_t frame;

    // odd parity bit for the outgoing byte
    logic tx_parity;

    assign tx_parity = ~^tx_data;

    // --------------------------------------------------
    // frame register
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame <= '1;
        end else if (load_tx) begin
            // stop, parity, data, start
            frame <= {1'b1, tx_parity, tx_data, 1'b0};
        end else if (shift) begin
            // line enters at the top, after a full frame the start bit is at 0
            frame <= {data_level, frame[`PS2_FRAME_BITS-1:1]};
        end
    end

    // bits moved so far in either direction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_count <= '0;
        end else if (clear_count) begin
            bit_count <= '0;
        end else if (shift) begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    // next bit to put on the wire when sending
    assign tx_bit = frame[0];

    // data plus parity must hold an odd number of ones
    assign parity_ok = ^frame[`PS2_PARITY_POS:1];

    // holds the last good byte until the next good frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_data <= '0;
        end else if (load_rx) begin
            rx_data <= frame[`PS2_PARITY_POS-1:1];
        end
    end

endmodule

`default_nettype wire

//--- source/ps2_link_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_link_fsm
    import ps2_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           clk_level,
    input  logic           data_level,
    input  logic           write,
    input  logic           rts_done,
    input  logic           setup_done,
    input  logic           release_done,
    input  logic           tx_bit,
    input  logic           parity_ok,
    input  ps2_bit_count_t bit_count,
    output logic           rts_enable,
    output logic           setup_enable,
    output logic           release_enable,
    output logic           load_tx,
    output logic           shift,
    output logic           clear_count,
    output logic           load_rx,
    output logic           ps2_clk_low,
    output logic           ps2_data_low,
    output logic           busy,
    output logic           read,
    output logic           err
);

    localparam ps2_bit_count_t RX_LAST = ps2_bit_count_t'(`PS2_FRAME_BITS);
    // start bit goes out during request-to-send, so one shift fewer
    localparam ps2_bit_count_t TX_LAST = ps2_bit_count_t'(`PS2_FRAME_BITS - 1);

    ps2_state_t state;
    ps2_state_t state_next;
    logic       data_low_next;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            // device pulling clock low wins over a client write
            idle: begin
                if (!clk_level) begin
                    state_next = rx_fall;
                end else if (write) begin
                    state_next = tx_hold_clk;
                end
            end

            // receive, one shift per falling edge
            rx_fall: state_next = rx_clk_low;
            rx_clk_low: begin
                if (clk_level) begin
                    state_next = rx_clk_high;
                end
            end
            rx_clk_high: begin
                if (bit_count == RX_LAST) begin
                    state_next = rx_check;
                end else if (!clk_level) begin
                    state_next = rx_fall;
                end
            end
            rx_check: state_next = parity_ok ? rx_ready : rx_parity_error;
            rx_ready: state_next = idle;
            rx_parity_error: state_next = idle;

            // request to send
            tx_hold_clk: begin
                if (rts_done) begin
                    state_next = tx_data_low;
                end
            end
            tx_data_low: begin
                if (setup_done) begin
                    state_next = tx_release_clk;
                end
            end
            // our own pull still shows through the filter for a while
            tx_release_clk: begin
                if (release_done) begin
                    state_next = tx_first_fall;
                end
            end
            tx_first_fall: begin
                if (!clk_level) begin
                    state_next = tx_drive_bit;
                end
            end

            // send, device samples on the rising edge
            tx_drive_bit: state_next = tx_wait_rise;
            tx_wait_rise: begin
                if (bit_count == TX_LAST) begin
                    state_next = tx_wait_ack_rise;
                end else if (clk_level) begin
                    state_next = tx_clk_high;
                end
            end
            tx_clk_high: begin
                if (!clk_level) begin
                    state_next = tx_drive_bit;
                end
            end

            // ack is data low at the next falling clock
            tx_wait_ack_rise: begin
                if (clk_level) begin
                    state_next = tx_wait_ack;
                end
            end
            tx_wait_ack: begin
                if (!clk_level) begin
                    state_next = data_level ? tx_no_ack : tx_acked;
                end
            end
            // bus must be fully released before going idle
            tx_acked, tx_no_ack: begin
                if (clk_level && data_level) begin
                    state_next = idle;
                end
            end

            default: state_next = idle;
        endcase
    end

    // data pull follows the frame LSB while shifting out
    always_comb begin
        case (state_next)
            tx_data_low, tx_release_clk, tx_first_fall: data_low_next = 1'b1;
            tx_drive_bit, tx_wait_rise, tx_clk_high: data_low_next = ~tx_bit;
            default: data_low_next = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // state and registered controls
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= idle;
            rts_enable     <= 1'b0;
            setup_enable   <= 1'b0;
            release_enable <= 1'b0;
            load_tx        <= 1'b0;
            shift          <= 1'b0;
            clear_count    <= 1'b0;
            load_rx        <= 1'b0;
            ps2_clk_low    <= 1'b0;
            ps2_data_low   <= 1'b0;
            busy           <= 1'b0;
            read           <= 1'b0;
            err            <= 1'b0;
        end else begin
            state          <= state_next;
            rts_enable     <= (state_next == tx_hold_clk);
            setup_enable   <= (state_next == tx_data_low);
            release_enable <= (state_next == tx_release_clk);
            // frame captured once, tx_data taken the cycle after write
            load_tx        <= (state == idle) && (state_next == tx_hold_clk);
            shift          <= (state_next == rx_fall) || (state_next == tx_drive_bit);
            clear_count    <= (state_next == idle);
            // rx_data updates before the read pulse
            load_rx        <= (state_next == rx_check) && parity_ok;
            ps2_clk_low    <= (state_next == tx_hold_clk) || (state_next == tx_data_low);
            ps2_data_low   <= data_low_next;
            busy           <= (state_next != idle);
            read           <= (state_next == rx_ready);
            // no-ack error lands together with busy falling
            err            <= (state_next == rx_parity_error) ||
                              ((state == tx_no_ack) && (state_next == idle));
        end
    end

endmodule

`default_nettype wire

//--- source/ps2_host.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_host
    import ps2_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ps2_clk_in,
    input  logic      ps2_data_in,
    input  logic      write,
    input  ps2_byte_t tx_data,
    output logic      ps2_clk_low,
    output logic      ps2_data_low,
    output logic      read,
    output logic      busy,
    output logic      err,
    output ps2_byte_t rx_data
);

    // clean line levels
    logic clk_level;
    logic data_level;

    // timer handshakes
    logic rts_enable;
    logic setup_enable;
    logic release_enable;
    logic rts_done;
    logic setup_done;
    logic release_done;

    // shifter controls and status
    logic           load_tx;
    logic           shift;
    logic           clear_count;
    logic           load_rx;
    logic           tx_bit;
    logic           parity_ok;
    ps2_bit_count_t bit_count;

    // --------------------------------------------------
    // line filters
    // --------------------------------------------------
    ps2_line_filter u_clk_filter (
        .clk   (clk),
        .rst   (rst),
        .raw   (ps2_clk_in),
        .level (clk_level)
    );

    ps2_line_filter u_data_filter (
        .clk   (clk),
        .rst   (rst),
        .raw   (ps2_data_in),
        .level (data_level)
    );

    // --------------------------------------------------
    // request-to-send timers
    // --------------------------------------------------
    ps2_delay_timer #(.LIMIT(`PS2_DELAY_RTS)) u_rts_timer (
        .clk    (clk),
        .rst    (rst),
        .enable (rts_enable),
        .done   (rts_done)
    );

    ps2_delay_timer #(.LIMIT(`PS2_DELAY_DATA_SETUP)) u_setup_timer (
        .clk    (clk),
        .rst    (rst),
        .enable (setup_enable),
        .done   (setup_done)
    );

    ps2_delay_timer #(.LIMIT(`PS2_DELAY_RELEASE)) u_release_timer (
        .clk    (clk),
        .rst    (rst),
        .enable (release_enable),
        .done   (release_done)
    );

    // --------------------------------------------------
    // datapath and control
    // --------------------------------------------------
    ps2_frame_shifter u_shifter (
        .clk         (clk),
        .rst         (rst),
        .load_tx     (load_tx),
        .shift       (shift),
        .clear_count (clear_count),
        .load_rx     (load_rx),
        .data_level  (data_level),
        .tx_data     (tx_data),
        .bit_count   (bit_count),
        .tx_bit      (tx_bit),
        .parity_ok   (parity_ok),
        .rx_data     (rx_data)
    );

    ps2_link_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .clk_level      (clk_level),
        .data_level     (data_level),
        .write          (write),
        .rts_done       (rts_done),
        .setup_done     (setup_done),
        .release_done   (release_done),
        .tx_bit         (tx_bit),
        .parity_ok      (parity_ok),
        .bit_count      (bit_count),
        .rts_enable     (rts_enable),
        .setup_enable   (setup_enable),
        .release_enable (release_enable),
        .load_tx        (load_tx),
        .shift          (shift),
        .clear_count    (clear_count),
        .load_rx        (load_rx),
        .ps2_clk_low    (ps2_clk_low),
        .ps2_data_low   (ps2_data_low),
        .busy           (busy),
        .read           (read),
        .err            (err)
    );

endmodule

`default_nettype wire

//--- tb/ps2_host_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_host_assert (
    input  logic clk,
    input  logic rst,
    input  logic read,
    input  logic err,
    input  logic busy,
    input  logic ps2_clk_low,
    input  logic ps2_data_low,
    output logic failed
);

    // one sticky flag per property
    logic overlap_failed = 1'b0;
    logic read_len_failed = 1'b0;
    logic err_len_failed = 1'b0;
    logic drive_failed = 1'b0;

    assign failed = overlap_failed | read_len_failed | err_len_failed | drive_failed;

    // --------------------------------------------------
    // client pulses
    // --------------------------------------------------
    // a frame ends either good or bad, never both
    read_err_exclusive: assert property (@(posedge clk) disable iff (rst) !(read && err))
        else begin
            overlap_failed = 1'b1;
            $error("read and err high in the same cycle");
        end

    read_one_cycle: assert property (@(posedge clk) disable iff (rst) read |=> !read)
        else begin
            read_len_failed = 1'b1;
            $error("read held longer than one cycle");
        end

    err_one_cycle: assert property (@(posedge clk) disable iff (rst) err |=> !err)
        else begin
            err_len_failed = 1'b1;
            $error("err held longer than one cycle");
        end

    // --------------------------------------------------
    // line drive
    // --------------------------------------------------
    // host only pulls the bus while a transfer is in progress
    pull_implies_busy: assert property (
        @(posedge clk) disable iff (rst) (ps2_clk_low || ps2_data_low) |-> busy)
        else begin
            drive_failed = 1'b1;
            $error("bus pulled low while busy is low");
        end

endmodule

bind ps2_host ps2_host_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .read         (read),
    .err          (err),
    .busy         (busy),
    .ps2_clk_low  (ps2_clk_low),
    .ps2_data_low (ps2_data_low),
    .failed       ()
);

`default_nettype wire

//--- tb/ps2_host_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_host_tb
    import ps2_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    // device clock half period, in clk cycles
    localparam int HALF_BIT = 40;
    // tx tests take about 7300 cycles each, rx frames about 1000
    localparam int CYCLE_LIMIT = 60000;

    logic      clk;
    logic      rst;
    logic      write;
    ps2_byte_t tx_data;
    logic      ps2_clk_in;
    logic      ps2_data_in;
    logic      ps2_clk_low;
    logic      ps2_data_low;
    logic      read;
    logic      busy;
    logic      err;
    ps2_byte_t rx_data;

    // device side pull, 1 means released
    logic dev_clk;
    logic dev_data;

    int        seed;
    int        cycle_count;
    int        read_count;
    int        err_count;
    int        clk_low_count;
    ps2_byte_t last_read_data;
    ps2_byte_t last_good;

    // wired-AND of device and host pulls
    assign ps2_clk_in  = dev_clk & ~ps2_clk_low;
    assign ps2_data_in = dev_data & ~ps2_data_low;

    ps2_host dut (
        .clk          (clk),
        .rst          (rst),
        .ps2_clk_in   (ps2_clk_in),
        .ps2_data_in  (ps2_data_in),
        .write        (write),
        .tx_data      (tx_data),
        .ps2_clk_low  (ps2_clk_low),
        .ps2_data_low (ps2_data_low),
        .read         (read),
        .busy         (busy),
        .err          (err),
        .rx_data      (rx_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_byte(input ps2_byte_t got, input ps2_byte_t exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("ERR at %0t ns: %s is %02h, expected %02h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("ERR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // all stimulus lands 2 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic wait_busy_low(input int max_cycles, input string what);
        int waited;
        waited = 0;
        while (busy && waited < max_cycles) begin
            wait_cycles(1);
            waited++;
        end
        if (busy) begin
            fail_now($sformatf("%s: busy did not fall within %0d cycles", what, max_cycles));
        end
    endtask

    task automatic wait_busy_high(input int max_cycles, input string what);
        int waited;
        waited = 0;
        while (!busy && waited < max_cycles) begin
            wait_cycles(1);
            waited++;
        end
        if (!busy) begin
            fail_now($sformatf("%s: busy did not rise within %0d cycles", what, max_cycles));
        end
    endtask

    // parity bit that makes the count of ones in data plus parity odd
    function automatic logic odd_parity(input ps2_byte_t value);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            if (value[i]) begin
                ones++;
            end
        end
        return (ones % 2 == 0);
    endfunction

    function automatic ps2_byte_t next_random_byte();
        logic [31:0] word;
        word = $random(seed);
        return word[7:0];
    endfunction

    // --------------------------------------------------
    // device model
    // --------------------------------------------------
    // device to host, data changes mid high phase, host reads on the fall
    task automatic send_frame(input ps2_byte_t value, input logic bad_parity);
        logic [`PS2_FRAME_BITS-1:0] bits;
        bits = {1'b1, odd_parity(value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            dev_data = bits[i];
            wait_cycles(HALF_BIT / 2);
            dev_clk = 1'b0;
            wait_cycles(HALF_BIT);
            dev_clk = 1'b1;
            wait_cycles(HALF_BIT / 2);
        end
        dev_data = 1'b1;
    endtask

    // host to device, 10 rising edge samples then the ack clock
    task automatic clock_host_frame(input logic give_ack, output logic [9:0] sampled);
        wait_cycles(100);
        for (int i = 0; i < 10; i++) begin
            dev_clk = 1'b0;
            wait_cycles(HALF_BIT);
            dev_clk = 1'b1;
            sampled[i] = ps2_data_in;
            wait_cycles(HALF_BIT / 2);
            // ack goes low before the 11th fall
            if (i == 9 && give_ack) begin
                dev_data = 1'b0;
            end
            wait_cycles(HALF_BIT / 2);
        end
        dev_clk = 1'b0;
        wait_cycles(HALF_BIT);
        dev_clk = 1'b1;
        wait_cycles(HALF_BIT / 2);
        dev_data = 1'b1;
    endtask

    // --------------------------------------------------
    // monitor and timeout
    // --------------------------------------------------
    // negedge sampling keeps clear of the DUT's register updates
    always @(negedge clk) begin
        if (rst) begin
            read_count    <= 0;
            err_count     <= 0;
            clk_low_count <= 0;
        end else begin
            if (read) begin
                read_count     <= read_count + 1;
                last_read_data <= rx_data;
            end
            if (err) begin
                err_count <= err_count + 1;
            end
            if (ps2_clk_low) begin
                clk_low_count <= clk_low_count + 1;
            end
            if (dut.u_assert.failed) begin
                fail_now("a bound assertion on ps2_host failed, see the error above");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_now($sformatf("timeout: the run went past %0d clock cycles", CYCLE_LIMIT));
        end
    end

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_values();
        check_flag(read, 1'b0, "read after reset");
        check_flag(err, 1'b0, "err after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(ps2_clk_low, 1'b0, "ps2_clk_low after reset");
        check_flag(ps2_data_low, 1'b0, "ps2_data_low after reset");
    endtask

    task automatic test_rx_good(input int frames);
        ps2_byte_t value;
        int        reads_before;
        int        errs_before;
        for (int n = 0; n < frames; n++) begin
            value        = next_random_byte();
            reads_before = read_count;
            errs_before  = err_count;
            send_frame(value, 1'b0);
            wait_busy_low(200, "good frame");
            wait_cycles(2);
            check_flag(logic'(read_count - reads_before == 1), 1'b1, "one read pulse per frame");
            check_flag(logic'(err_count == errs_before), 1'b1, "no err on a good frame");
            check_byte(last_read_data, value, "rx_data in the read cycle");
            check_byte(rx_data, value, "rx_data after the frame");
            check_flag(busy, 1'b0, "busy after a good frame");
            last_good = value;
            wait_cycles(100);
        end
    endtask

    task automatic test_rx_bad_parity();
        ps2_byte_t value;
        int        reads_before;
        int        errs_before;
        value = next_random_byte();
        if (value == last_good) begin
            value = ~value;
        end
        reads_before = read_count;
        errs_before  = err_count;
        send_frame(value, 1'b1);
        wait_busy_low(200, "bad parity frame");
        wait_cycles(2);
        check_flag(logic'(err_count - errs_before == 1), 1'b1, "one err pulse on bad parity");
        check_flag(logic'(read_count == reads_before), 1'b1, "no read on bad parity");
        check_byte(rx_data, last_good, "rx_data kept over a bad frame");
        wait_cycles(100);
    endtask

    task automatic test_tx(input logic give_ack);
        ps2_byte_t  value;
        int         errs_before;
        int         waited;
        int         hold;
        logic [9:0] sampled;
        value       = next_random_byte();
        errs_before = err_count;
        tx_data     = value;
        write       = 1'b1;
        wait_cycles(1);
        write  = 1'b0;
        waited = 0;
        while (!ps2_clk_low && waited < 10) begin
            wait_cycles(1);
            waited++;
        end
        if (!ps2_clk_low) begin
            fail_now("transmit: ps2_clk_low never rose after write");
        end
        // request-to-send clock hold
        hold = 0;
        while (ps2_clk_low && hold < `PS2_DELAY_RTS + `PS2_DELAY_DATA_SETUP + 500) begin
            wait_cycles(1);
            hold++;
        end
        if (ps2_clk_low) begin
            fail_now("transmit: ps2_clk_low was never released");
        end
        check_flag(logic'(hold >= `PS2_DELAY_RTS), 1'b1,
                   $sformatf("clock hold of %0d cycles reaching the minimum", hold));
        check_flag(ps2_data_low, 1'b1, "ps2_data_low at clock release");
        clock_host_frame(give_ack, sampled);
        check_byte(sampled[7:0], value, "transmitted data bits");
        check_flag(sampled[8], odd_parity(value), "transmitted parity bit");
        check_flag(sampled[9], 1'b1, "transmitted stop bit");
        wait_busy_low(300, "transmit end");
        wait_cycles(2);
        if (give_ack) begin
            check_flag(logic'(err_count == errs_before), 1'b1, "no err after an ack");
        end else begin
            check_flag(logic'(err_count - errs_before == 1), 1'b1, "one err without an ack");
        end
        check_flag(busy, 1'b0, "busy after transmit");
        wait_cycles(100);
    endtask

    task automatic test_write_during_rx();
        ps2_byte_t value;
        int        reads_before;
        int        low_before;
        value        = next_random_byte();
        reads_before = read_count;
        low_before   = clk_low_count;
        tx_data      = ~value;
        fork
            send_frame(value, 1'b0);
            begin
                wait_busy_high(200, "write during receive");
                wait_cycles(HALF_BIT);
                write = 1'b1;
                wait_cycles(1);
                write = 1'b0;
            end
        join
        wait_busy_low(200, "write during receive");
        wait_cycles(20);
        check_flag(logic'(clk_low_count == low_before), 1'b1, "no clock pull during receive");
        check_flag(logic'(read_count - reads_before == 1), 1'b1, "read pulse with a stray write");
        check_byte(rx_data, value, "rx_data with a stray write");
        check_flag(busy, 1'b0, "busy after the stray write");
    endtask

    initial begin
        seed      = 32'h8e7a;
        rst       = 1'b1;
        write     = 1'b0;
        tx_data   = '0;
        dev_clk   = 1'b1;
        dev_data  = 1'b1;
        last_good = '0;
        wait_cycles(2);
        rst = 1'b0;
        test_reset_values();
        wait_cycles(50);
        test_rx_good(4);
        test_rx_bad_parity();
        test_tx(1'b1);
        test_tx(1'b0);
        test_write_during_rx();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
source/ps2_pkg.sv
source/ps2_line_filter.sv
source/ps2_delay_timer.sv
source/ps2_frame_shifter.sv
source/ps2_link_fsm.sv
source/ps2_host.sv
tb/ps2_host_assert.sv
tb/ps2_host_tb.sv

//--- run.sh
#!/bin/sh
# build the ps2_host testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
        --top-module ps2_host_tb -o ps2_host_sim \
    && ./obj_dir/ps2_host_sim +verilator+error+limit+100 | tee /dev/stderr \
        | grep -F "Simulation finished: PASS" > /dev/null \
    && echo "ps2_host: test run passed" \
    || { echo "ps2_host: test run failed"; exit 1; }
